// File: design/beam_consts.svh
// ==================================================
// beamformer constants
// widths, channel count, weight scaling and the
// credit depth shared by the whole beamformer
// ==================================================
`ifndef BEAM_CONSTS_SVH
`define BEAM_CONSTS_SVH

// one sample is a signed 16-bit word
`define BEAM_SAMPLE_WIDTH 16
// each weight part is signed with 7 fraction bits
`define BEAM_WEIGHT_WIDTH 8
`define BEAM_WEIGHT_FRAC 7
// a beat carries eight samples per channel
`define BEAM_SAMPLES 8
`define BEAM_CHANNELS 4
// downstream slots granted after reset, and the width of the count
`define BEAM_OUT_CREDITS 4
`define BEAM_CREDIT_WIDTH 3
// edges from acceptance to output, counting the acceptance edge
`define BEAM_PIPE_DEPTH 4

`endif

// File: design/beam_pkg.sv
// ==================================================
// beamformer types
// sample, weight and beat types for the datapath
// ==================================================
`default_nettype none

package beam_pkg;

    `include "beam_consts.svh"

    // a signed sample as it arrives from one antenna channel
    typedef logic signed [`BEAM_SAMPLE_WIDTH-1:0] sample_t;

    // one part of a complex weight, in fixed point with BEAM_WEIGHT_FRAC fraction bits
    typedef logic signed [`BEAM_WEIGHT_WIDTH-1:0] weight_t;

    // eight samples that travel together in one beat
    typedef sample_t [`BEAM_SAMPLES-1:0] beat_t;

    // one beat per channel, index 0 is channel 0
    typedef beat_t [`BEAM_CHANNELS-1:0] chan_beats_t;

    // one weight part per channel
    typedef weight_t [`BEAM_CHANNELS-1:0] chan_weights_t;

endpackage

`default_nettype wire

// File: design/output_credit_counter.sv
// ==================================================
// output credit counter
// tracks the free slots of the downstream sink
// ==================================================
`default_nettype none
`timescale 1ns/100ps

`include "beam_consts.svh"

module output_credit_counter #(
    parameter int max_credits = `BEAM_OUT_CREDITS
) (
    input  wire  clock,
    input  wire  resetn,
    input  wire  accept,
    input  wire  credit_return,
    output logic credit_available
);

    logic [`BEAM_CREDIT_WIDTH-1:0] credit_count;

    // the sink owns max_credits slots when it leaves reset
    // an accepted beat takes a slot at once, while it is still in the pipeline
    // a returned credit hands one slot back
    always_ff @(posedge clock) begin
        if (!resetn) begin
            credit_count <= `BEAM_CREDIT_WIDTH'(max_credits);
        end else begin
            case ({accept, credit_return})
                2'b10:   credit_count <= credit_count - 1'b1;
                2'b01:   credit_count <= credit_count + 1'b1;
                // a take and a return on the same edge cancel out
                default: credit_count <= credit_count;
            endcase
        end
    end

    // no accept can happen without a free slot
    assign credit_available = (credit_count != '0);

endmodule

`default_nettype wire

// File: design/frame_sequencer.sv
// ==================================================
// frame sequencer
// input handshake, frame tracking for the weight
// load, and the valid/last tag pipeline
// ==================================================
`default_nettype none
`timescale 1ns/100ps

`include "beam_consts.svh"

module frame_sequencer (
    input  wire  clock,
    input  wire  resetn,
    input  wire  in_valid,
    input  wire  in_last,
    input  wire  credit_available,
    output logic in_ready,
    output logic accept,
    output logic weight_load,
    output logic out_valid,
    output logic out_last
);

    typedef enum logic {
        frame_idle,
        frame_active
    } frame_state_t;

    frame_state_t state;
    logic         ready_en;

    // one bit per pipeline edge, bit 0 is written on the acceptance edge
    logic [`BEAM_PIPE_DEPTH-1:0] valid_pipe;
    logic [`BEAM_PIPE_DEPTH-1:0] last_pipe;

    // ready_en keeps in_ready low until the first edge after reset is released
    always_ff @(posedge clock) begin
        if (!resetn) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    // the sink must have room for every beat the pipeline accepts
    assign in_ready = ready_en && credit_available;
    assign accept   = in_valid && in_ready;

    // a frame starts on the beat after the one that carried in_last
    // the multipliers only load weights when this strobe meets an accept
    assign weight_load = (state == frame_idle);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= frame_idle;
        end else if (accept) begin
            if (in_last) begin
                state <= frame_idle;
            end else begin
                state <= frame_active;
            end
        end
    end

    // the tags shift alongside the datapath so that out_valid and out_last
    // rise with the summed beat on the fourth edge counting the acceptance edge
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`BEAM_PIPE_DEPTH-2:0], accept};
            last_pipe  <= {last_pipe[`BEAM_PIPE_DEPTH-2:0], accept && in_last};
        end
    end

    assign out_valid = valid_pipe[`BEAM_PIPE_DEPTH-1];
    assign out_last  = last_pipe[`BEAM_PIPE_DEPTH-1];

endmodule

`default_nettype wire

// File: design/complex_weight_mult.sv
// ==================================================
// complex weight multiplier
// holds one channel's weight and multiplies each
// sample of a beat by it in three pipeline stages
// ==================================================
`default_nettype none
`timescale 1ns/100ps

`include "beam_consts.svh"

module complex_weight_mult (
    input  wire             clock,
    input  wire             resetn,
    input  wire beam_pkg::beat_t   sample_real,
    input  wire beam_pkg::beat_t   sample_imag,
    input  wire beam_pkg::weight_t weight_in_real,
    input  wire beam_pkg::weight_t weight_in_imag,
    input  wire             weight_load,
    input  wire             accept,
    output beam_pkg::beat_t prod_real,
    output beam_pkg::beat_t prod_imag
);

    import beam_pkg::*;

    // a full product needs the sum of both operand widths
    localparam int prod_width = `BEAM_SAMPLE_WIDTH + `BEAM_WEIGHT_WIDTH;

    weight_t weight_real_q;
    weight_t weight_imag_q;
    beat_t   sample_real_q;
    beat_t   sample_imag_q;

    // the four partial products of every sample
    logic signed [prod_width-1:0] prod_rr [`BEAM_SAMPLES];
    logic signed [prod_width-1:0] prod_ii [`BEAM_SAMPLES];
    logic signed [prod_width-1:0] prod_ri [`BEAM_SAMPLES];
    logic signed [prod_width-1:0] prod_ir [`BEAM_SAMPLES];

    // the weights only change on the first accepted beat of a frame
    // so that beat is already multiplied by the new value in stage 2
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weight_real_q <= '0;
            weight_imag_q <= '0;
        end else if (weight_load && accept) begin
            weight_real_q <= weight_in_real;
            weight_imag_q <= weight_in_imag;
        end
    end

    // stage 1 captures the incoming samples on every edge
    // the valid tag travels separately in the frame sequencer
    always_ff @(posedge clock) begin
        sample_real_q <= sample_real;
        sample_imag_q <= sample_imag;
    end

    // stage 2 forms real*real, imag*imag, real*imag and imag*real
    // with the weight taken from the register loaded in stage 1
    always_ff @(posedge clock) begin
        for (int i = 0; i < `BEAM_SAMPLES; i++) begin
            prod_rr[i] <= $signed(sample_real_q[i]) * $signed(weight_real_q);
            prod_ii[i] <= $signed(sample_imag_q[i]) * $signed(weight_imag_q);
            prod_ri[i] <= $signed(sample_real_q[i]) * $signed(weight_imag_q);
            prod_ir[i] <= $signed(sample_imag_q[i]) * $signed(weight_real_q);
        end
    end

    // stage 3 drops the fraction bits of each product by an arithmetic shift
    // and keeps the low 16 bits, then combines the parts
    // the real part is rr - ii and the imaginary part is ri + ir
    // both results wrap around at 16 bits
    always_ff @(posedge clock) begin
        for (int i = 0; i < `BEAM_SAMPLES; i++) begin
            prod_real[i] <= sample_t'(prod_rr[i] >>> `BEAM_WEIGHT_FRAC)
                          - sample_t'(prod_ii[i] >>> `BEAM_WEIGHT_FRAC);
            prod_imag[i] <= sample_t'(prod_ri[i] >>> `BEAM_WEIGHT_FRAC)
                          + sample_t'(prod_ir[i] >>> `BEAM_WEIGHT_FRAC);
        end
    end

endmodule

`default_nettype wire

// File: design/channel_sum_adder.sv
// ==================================================
// channel sum adder
// adds the weighted channels sample by sample into
// one registered beam beat
// ==================================================
`default_nettype none
`timescale 1ns/100ps

`include "beam_consts.svh"

module channel_sum_adder (
    input  wire                   clock,
    input  wire                   resetn,
    input  wire beam_pkg::chan_beats_t chan_real,
    input  wire beam_pkg::chan_beats_t chan_imag,
    output beam_pkg::beat_t       sum_real,
    output beam_pkg::beat_t       sum_imag
);

    import beam_pkg::*;

    beat_t acc_real;
    beat_t acc_imag;

    // each sample lane accumulates in its own 16-bit slot
    // so any carry out of a lane is simply lost and the sum wraps
    always_comb begin
        acc_real = '0;
        acc_imag = '0;
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                acc_real[s] = acc_real[s] + chan_real[c][s];
                acc_imag[s] = acc_imag[s] + chan_imag[c][s];
            end
        end
    end

    // stage 4 of the datapath, which lines up with out_valid
    always_ff @(posedge clock) begin
        if (!resetn) begin
            sum_real <= '0;
            sum_imag <= '0;
        end else begin
            sum_real <= acc_real;
            sum_imag <= acc_imag;
        end
    end

endmodule

`default_nettype wire

// File: design/beamformer_top.sv
// ==================================================
// four-channel complex beamformer
// weights each channel by a complex factor held for
// a frame and sums them into one output beam
// ==================================================
`default_nettype none
`timescale 1ns/100ps

`include "beam_consts.svh"

module beamformer_top (
    input  wire                      clock,
    input  wire                      resetn,
    input  wire beam_pkg::chan_beats_t   in_real,
    input  wire beam_pkg::chan_beats_t   in_imag,
    input  wire                      in_last,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire beam_pkg::chan_weights_t weight_real,
    input  wire beam_pkg::chan_weights_t weight_imag,
    input  wire                      credit_return,
    output beam_pkg::beat_t          out_real,
    output beam_pkg::beat_t          out_imag,
    output logic                     out_last,
    output logic                     out_valid
);

    import beam_pkg::*;

    logic accept;
    logic weight_load;
    logic credit_available;

    // weighted beats of every channel, three edges after acceptance
    chan_beats_t chan_prod_real;
    chan_beats_t chan_prod_imag;

    // handshake, frame state and the tags that mark each output beat
    frame_sequencer u_frame_sequencer (
        .clock            (clock),
        .resetn           (resetn),
        .in_valid         (in_valid),
        .in_last          (in_last),
        .credit_available (credit_available),
        .in_ready         (in_ready),
        .accept           (accept),
        .weight_load      (weight_load),
        .out_valid        (out_valid),
        .out_last         (out_last)
    );

    // the output has no ready, so the input is throttled by the sink's credits
    output_credit_counter #(
        .max_credits (`BEAM_OUT_CREDITS)
    ) u_output_credit_counter (
        .clock            (clock),
        .resetn           (resetn),
        .accept           (accept),
        .credit_return    (credit_return),
        .credit_available (credit_available)
    );

    // every channel shares the accept and the weight load strobe
    // since the channels arrive sample aligned
    for (genvar c = 0; c < `BEAM_CHANNELS; c++) begin : g_chan
        complex_weight_mult u_complex_weight_mult (
            .clock          (clock),
            .resetn         (resetn),
            .sample_real    (in_real[c]),
            .sample_imag    (in_imag[c]),
            .weight_in_real (weight_real[c]),
            .weight_in_imag (weight_imag[c]),
            .weight_load    (weight_load),
            .accept         (accept),
            .prod_real      (chan_prod_real[c]),
            .prod_imag      (chan_prod_imag[c])
        );
    end

    // the last stage, whose register lines up with out_valid
    channel_sum_adder u_channel_sum_adder (
        .clock     (clock),
        .resetn    (resetn),
        .chan_real (chan_prod_real),
        .chan_imag (chan_prod_imag),
        .sum_real  (out_real),
        .sum_imag  (out_imag)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// ==================================================
// testbench clock and reset source
// free-running clock and a reset held low for a
// fixed number of cycles
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // reset is released right after the last reset edge
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/beamformer_tb.sv
// ==================================================
// beamformer testbench
// applies a table of frames, models the credit sink
// and checks every output beat against a reference
// ==================================================
`default_nettype none
`timescale 1ns/100ps

`include "beam_consts.svh"

module beamformer_tb;

    import beam_pkg::*;

    localparam int reset_cycles = 16;
    localparam int num_frames   = 8;

    // one frame per row, weights are {ch3, ch2, ch1, ch0}
    typedef struct packed {
        chan_weights_t w_real;
        chan_weights_t w_imag;
        int            beats;
        bit            change_weights;
        int            credit_pct;
    } frame_row_t;

    frame_row_t    frame_table [num_frames];
    logic          clock;
    logic          resetn;
    chan_beats_t   in_real;
    chan_beats_t   in_imag;
    logic          in_last;
    logic          in_valid;
    logic          in_ready;
    chan_weights_t weight_real;
    chan_weights_t weight_imag;
    logic          credit_return = 1'b0;
    beat_t         out_real;
    beat_t         out_imag;
    logic          out_last;
    logic          out_valid;

    int cycle_count = 0;
    int timeout_limit = 1000000;
    int total_beats = 0;
    int credit_pct = 100;
    int model_credits = `BEAM_OUT_CREDITS;
    int beats_accepted = 0;
    int beats_received = 0;
    int credits_returned = 0;
    int value_errors = 0;
    int other_errors = 0;
    bit model_idle = 1'b1;
    chan_weights_t model_wr;
    chan_weights_t model_wi;

    // beats in flight, in acceptance order, with the cycle they must leave on
    beat_t exp_real_q [$];
    beat_t exp_imag_q [$];
    bit    exp_last_q [$];
    int    exp_cycle_q [$];
    // beats held by the sink until it hands the slot back
    beat_t sink_fifo [$];

    tb_clock_gen #(
        .period_ns    (20),
        .reset_cycles (reset_cycles)
    ) u_tb_clock_gen (
        .clock  (clock),
        .resetn (resetn)
    );

    beamformer_top u_beamformer_top (
        .clock         (clock),
        .resetn        (resetn),
        .in_real       (in_real),
        .in_imag       (in_imag),
        .in_last       (in_last),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .weight_real   (weight_real),
        .weight_imag   (weight_imag),
        .credit_return (credit_return),
        .out_real      (out_real),
        .out_imag      (out_imag),
        .out_last      (out_last),
        .out_valid     (out_valid)
    );

    // rows mix extreme weights, full and sparse credit return and frame lengths 1 to 6
    task automatic load_frame_table();
        frame_table[0] = '{32'h40404040, 32'h00000000, 1, 1'b0, 100};
        frame_table[1] = '{32'h7f7f7f7f, 32'h80808080, 6, 1'b1, 70};
        frame_table[2] = '{32'h10e030c0, 32'h05fb7090, 3, 1'b0, 40};
        frame_table[3] = '{32'h01020304, 32'hfffefdfc, 4, 1'b1, 90};
        frame_table[4] = '{32'h80808080, 32'h7f7f7f7f, 2, 1'b0, 30};
        frame_table[5] = '{32'h5aa63cc4, 32'h19e7669a, 5, 1'b1, 60};
        frame_table[6] = '{32'h00000000, 32'h40c040c0, 6, 1'b0, 100};
        frame_table[7] = '{32'h7fe01f80, 32'h218e61d3, 1, 1'b1, 50};
    endtask

    // product of a sample and a weight part, floor-shifted by the fraction bits
    // and cut to one sample width
    function automatic sample_t scale_product(input sample_t x, input weight_t w);
        int p;
        p = x * w;
        p = p >>> `BEAM_WEIGHT_FRAC;
        return p[`BEAM_SAMPLE_WIDTH-1:0];
    endfunction

    task automatic compute_expected(input chan_beats_t re, input chan_beats_t im,
                                    input chan_weights_t wr, input chan_weights_t wi,
                                    output beat_t er, output beat_t ei);
        sample_t acc_r;
        sample_t acc_i;
        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            acc_r = '0;
            acc_i = '0;
            // every channel result and the running sum wrap at 16 bits
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                acc_r = acc_r + scale_product(re[c][s], wr[c])
                              - scale_product(im[c][s], wi[c]);
                acc_i = acc_i + scale_product(re[c][s], wi[c])
                              + scale_product(im[c][s], wr[c]);
            end
            er[s] = acc_r;
            ei[s] = acc_i;
        end
    endtask

    task automatic fill_random_beats(output chan_beats_t re, output chan_beats_t im);
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                re[c][s] = 16'($urandom);
                im[c][s] = 16'($urandom);
            end
        end
    endtask

    // called on the negedge before the acceptance edge
    task automatic record_accept();
        beat_t er;
        beat_t ei;
        // the first beat of a frame latches the weights on the ports
        if (model_idle) begin
            model_wr = weight_real;
            model_wi = weight_imag;
        end
        compute_expected(in_real, in_imag, model_wr, model_wi, er, ei);
        exp_real_q.push_back(er);
        exp_imag_q.push_back(ei);
        exp_last_q.push_back(in_last);
        exp_cycle_q.push_back(cycle_count + `BEAM_PIPE_DEPTH);
        model_idle = in_last;
        model_credits--;
        beats_accepted++;
        assert (model_credits >= 0) else begin
            other_errors++;
            $display("beat accepted at %0t with no free credit in the sink", $time);
        end
    endtask

    task automatic check_output_beat();
        bit late;
        if (out_valid === 1'b1) begin
            beats_received++;
            assert (exp_real_q.size() > 0) else begin
                other_errors++;
                $display("output beat at %0t with no accepted beat waiting", $time);
            end
            if (exp_real_q.size() > 0) begin
                assert (exp_cycle_q[0] == cycle_count) else begin
                    value_errors++;
                    $display("[ERROR] %0t out_valid cycle: expected %0d, got %0d",
                             $time, exp_cycle_q[0], cycle_count);
                end
                assert (out_real === exp_real_q[0]) else begin
                    value_errors++;
                    $display("[ERROR] %0t out_real: expected %h, got %h",
                             $time, exp_real_q[0], out_real);
                end
                assert (out_imag === exp_imag_q[0]) else begin
                    value_errors++;
                    $display("[ERROR] %0t out_imag: expected %h, got %h",
                             $time, exp_imag_q[0], out_imag);
                end
                assert (out_last === exp_last_q[0]) else begin
                    value_errors++;
                    $display("[ERROR] %0t out_last: expected %b, got %b",
                             $time, exp_last_q[0], out_last);
                end
                void'(exp_real_q.pop_front());
                void'(exp_imag_q.pop_front());
                void'(exp_last_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
            sink_fifo.push_back(out_real);
            assert (sink_fifo.size() <= `BEAM_OUT_CREDITS) else begin
                other_errors++;
                $display("sink overflow at %0t, more beats than granted slots", $time);
            end
        end else if (exp_cycle_q.size() > 0) begin
            late = (exp_cycle_q[0] <= cycle_count);
            assert (!late) else begin
                other_errors++;
                $display("an accepted beat never came out on its cycle %0d", exp_cycle_q[0]);
            end
            // drop the lost beat so the rest still line up
            if (late) begin
                void'(exp_real_q.pop_front());
                void'(exp_imag_q.pop_front());
                void'(exp_last_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end
    endtask

    // all monitoring runs on the falling edge where every DUT output is settled
    always @(negedge clock) begin
        if (resetn) begin
            assert (!(model_credits == 0 && in_ready === 1'b1)) else begin
                other_errors++;
                $display("in_ready high at %0t while the sink has no free slot", $time);
            end
            check_output_beat();
            if (in_valid === 1'b1 && in_ready === 1'b1) begin
                record_accept();
            end
            if (credit_return === 1'b1) begin
                model_credits++;
                credits_returned++;
            end
        end
    end

    // the sink frees one slot at a time, at random, with the row's probability
    always @(posedge clock) begin
        if (!resetn) begin
            credit_return <= 1'b0;
        end else if (sink_fifo.size() > 0 && $urandom_range(99) < credit_pct) begin
            credit_return <= 1'b1;
            sink_fifo.delete(0);
        end else begin
            credit_return <= 1'b0;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_limit);
            $display("%0d value errors, %0d other errors", value_errors, other_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_reset();
        @(negedge clock);
        while (!resetn) begin
            assert (in_ready === 1'b0 && out_valid === 1'b0 && out_last === 1'b0) else begin
                other_errors++;
                $display("in_ready, out_valid or out_last high during reset at %0t", $time);
            end
            @(negedge clock);
        end
        // ready follows one edge after the release
        @(negedge clock);
        assert (in_ready === 1'b1) else begin
            other_errors++;
            $display("in_ready did not rise on the first edge after reset");
        end
    endtask

    task automatic run_frame(input frame_row_t row);
        chan_beats_t re;
        chan_beats_t im;
        int gap;
        // the sink picks up the new rate from the next edge on
        credit_pct <= row.credit_pct;
        for (int b = 0; b < row.beats; b++) begin
            @(posedge clock);
            fill_random_beats(re, im);
            in_real  <= re;
            in_imag  <= im;
            in_valid <= 1'b1;
            in_last  <= (b == row.beats - 1);
            if (b == 0) begin
                weight_real <= row.w_real;
                weight_imag <= row.w_imag;
            end else if (row.change_weights) begin
                // these must not reach the beats of the running frame
                weight_real <= $urandom;
                weight_imag <= $urandom;
            end
            // the beat is held until a credit lets it in
            @(negedge clock);
            while (in_ready !== 1'b1) begin
                @(negedge clock);
            end
        end
        // sometimes the next frame follows back to back
        gap = $urandom_range(2);
        if (gap > 0) begin
            @(posedge clock);
            in_valid <= 1'b0;
            in_last  <= 1'b0;
            repeat (gap - 1) @(posedge clock);
        end
    endtask

    initial begin
        void'($urandom(31));
        in_real       <= '0;
        in_imag       <= '0;
        in_last       <= 1'b0;
        in_valid      <= 1'b0;
        weight_real   <= '0;
        weight_imag   <= '0;
        load_frame_table();
        for (int r = 0; r < num_frames; r++) begin
            total_beats += frame_table[r].beats;
        end
        timeout_limit = reset_cycles + 10 * total_beats + 50;
        check_reset();
        for (int r = 0; r < num_frames; r++) begin
            run_frame(frame_table[r]);
        end
        @(posedge clock);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        while (exp_real_q.size() > 0) begin
            @(negedge clock);
        end
        // a few more cycles catch any stray beat
        repeat (4) @(negedge clock);
        assert (beats_accepted == total_beats && beats_received == beats_accepted) else begin
            other_errors++;
            $display("beat count mismatch, %0d in the table, %0d accepted, %0d received",
                     total_beats, beats_accepted, beats_received);
        end
        $display("%0d beats accepted, %0d beats received, %0d value errors, %0d other errors",
                 beats_accepted, beats_received, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/beam_pkg.sv
design/output_credit_counter.sv
design/frame_sequencer.sv
design/complex_weight_mult.sv
design/channel_sum_adder.sv
design/beamformer_top.sv
test/tb_clock_gen.sv
test/beamformer_tb.sv
